//--- logic/fieldIf.sv
`timescale 1ns/1ps

interface fieldIf;

	logic resetBlocks; // Restart the piece; with pause high also clear the stack.
	logic pause;
	logic hitBottom;   // One cycle per landing.
	logic endGame;

	modport ctrl
	(
		output resetBlocks, pause,
		input hitBottom, endGame
	);

	modport field
	(
		input resetBlocks, pause,
		output hitBottom, endGame
	);

endinterface

//--- logic/gameController.sv
`timescale 1ns/1ps

module gameController import tetrisPkg::*;
(
	input logic Clk,
	input logic rstN,
	input logic [7:0] keyCode,
	fieldIf.ctrl field,
	output pieceShape_t blockState,
	output logic [5:0] spriteIndex,
	output pieceShape_t holdState,
	output logic [5:0] holdIndex,
	output pieceShape_t queueState,
	output logic [5:0] queueIndex,
	output logic [2:0] screen
);

	enum logic [3:0] {Wait, Drop1, Drop2, DropNoReset, Falling, Hold1, Bottom, PauseState,
		EndScreen} state, nextState;

	logic canHold, canHoldNext;
	logic resetPiece, resetBlocksNext, pauseNext;
	logic [2:0] screenNext;
	pieceShape_t blockNext, holdNext, queueNext, pickState;
	logic [5:0] spriteNext, holdIndexNext, queueIndexNext, pickIndex;

	pieceGenerator picker
	(
		.Clk,
		.rstN,
		.pickPiece(resetPiece),
		.blockState(pickState),
		.spriteIndex(pickIndex)
	);

	always_ff @(posedge Clk)
	begin
		if (!rstN)
		begin
			state <= Wait;
			canHold <= 1'b1;
			holdState <= '0;
			queueState <= '0;
			field.resetBlocks <= 1'b1;
			field.pause <= 1'b1;
			screen <= screenTitle;
		end
		else
		begin
			state <= nextState;
			canHold <= canHoldNext;
			holdState <= holdNext;
			queueState <= queueNext;
			field.resetBlocks <= resetBlocksNext;
			field.pause <= pauseNext;
			screen <= screenNext;
		end
	end

	always_ff @(posedge Clk)
	begin
		blockState <= blockNext;
		spriteIndex <= spriteNext;
		holdIndex <= holdIndexNext;
		queueIndex <= queueIndexNext;
	end

	always_comb
	begin
		nextState = state;
		unique case (state)
			Wait:
				if (keyCode == keySpace && queueState.flat != '0)
					nextState = Drop1;
			Drop1:
				nextState = Drop2;
			Drop2, DropNoReset:
				nextState = Falling;
			Falling:
				if (field.hitBottom)
					nextState = Bottom;
				else if (keyCode == keyPause)
					nextState = PauseState;
				else if (keyCode == keyHold && canHold)
					nextState = Hold1;
				else if (keyCode == keyEscape)
					nextState = Wait;
			Hold1:
				nextState = DropNoReset;
			Bottom:
				nextState = field.endGame ? EndScreen : Drop1;
			PauseState:
				if (keyCode == keyResume)
					nextState = Falling;
			EndScreen:
				if (keyCode == keyEscape)
					nextState = Wait;
			default:
				nextState = Wait;
		endcase
	end

	always_comb
	begin
		canHoldNext = canHold;
		blockNext = blockState;
		spriteNext = spriteIndex;
		holdNext = holdState;
		holdIndexNext = holdIndex;
		queueNext = queueState;
		queueIndexNext = queueIndex;
		resetBlocksNext = 1'b0;
		resetPiece = 1'b0;
		case (state)
			Wait:
			begin
				resetBlocksNext = 1'b1;
				holdNext = '0;
				canHoldNext = 1'b1;
				// Two picks fill the queue and leave one waiting in the generator.
				if (queueState.flat == '0)
				begin
					resetPiece = 1'b1;
					queueNext = pickState;
					queueIndexNext = pickIndex;
				end
			end
			Drop1:
			begin
				resetBlocksNext = 1'b1;
				blockNext = queueState;
				spriteNext = queueIndex;
			end
			Drop2:
			begin
				resetPiece = 1'b1;
				queueNext = pickState;
				queueIndexNext = pickIndex;
			end
			DropNoReset:
				resetBlocksNext = 1'b1;
			Hold1:
			begin
				holdNext = blockState;
				holdIndexNext = spriteIndex;
				canHoldNext = 1'b0;
				if (holdState.flat == '0) // First hold takes from the queue.
				begin
					resetPiece = 1'b1;
					blockNext = queueState;
					spriteNext = queueIndex;
					queueNext = pickState;
					queueIndexNext = pickIndex;
				end
				else
				begin
					blockNext = holdState;
					spriteNext = holdIndex;
				end
			end
			Bottom:
				canHoldNext = 1'b1;
			EndScreen:
				resetBlocksNext = 1'b1;
			default:
			begin
			end
		endcase
	end

	// Decoded from the next state so the registers line up with the state.
	always_comb
	begin
		pauseNext = 1'b1;
		case (nextState)
			Wait: screenNext = screenTitle;
			PauseState: screenNext = screenPaused;
			EndScreen: screenNext = screenEnd;
			default:
			begin
				screenNext = screenPlay;
				pauseNext = 1'b0;
			end
		endcase
	end

	stateLegal: assert property (@(posedge Clk) disable iff (!rstN)
		state inside {Wait, Drop1, Drop2, DropNoReset, Falling, Hold1, Bottom, PauseState,
		EndScreen})
		else $error("Illegal controller state %h", state);

	pausedOffPlay: assert property (@(posedge Clk) disable iff (!rstN)
		screen != screenPlay |-> field.pause)
		else $error("Screen %h shown while the field runs", screen);

endmodule

//--- logic/pieceGenerator.sv
`timescale 1ns/1ps

module pieceGenerator import tetrisPkg::*;
(
	input logic Clk,
	input logic rstN,
	input logic pickPiece,
	output pieceShape_t blockState,
	output logic [5:0] spriteIndex
);

	logic [15:0] lfsr;
	logic [15:0] lfsrNext;
	logic feedback;
	logic [2:0] pickIndex;

	always_comb
	begin
		feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]; // Taps 16, 14, 13, 11.
		lfsrNext = {lfsr[14:0], feedback};
		pickIndex = 3'(lfsrNext[2:0] % 3'd7);
	end

	// A zero shape after reset tells the controller nothing is picked yet.
	always_ff @(posedge Clk)
	begin
		if (!rstN)
		begin
			lfsr <= lfsrSeed;
			blockState <= '0;
			spriteIndex <= '0;
		end
		else if (pickPiece)
		begin
			lfsr <= lfsrNext;
			blockState.flat <= shapeTable[pickIndex];
			spriteIndex <= {3'b000, pickIndex};
		end
	end

	// Zero is the lock-up state of this LFSR.
	lfsrNonZero: assert property (@(posedge Clk) disable iff (!rstN) lfsr != 16'h0000)
		else $error("LFSR stuck at zero");

endmodule

//--- logic/playfieldTracker.sv
`timescale 1ns/1ps

module playfieldTracker import tetrisPkg::*;
(
	input logic Clk,
	input logic rstN,
	fieldIf.field field,
	input pieceShape_t blockState,
	output logic [3:0] pieceRow,
	output logic [4:0] stackHeight
);

	logic [$clog2(fallPeriod)-1:0] fallTimer;
	logic [2:0] pieceHeight;
	logic landed; // Frozen until the controller restarts the piece.
	logic timerDone;
	logic atBottom;
	logic [5:0] stackSum;

	always_comb
	begin
		pieceHeight = '0;
		for (int r = 0; r < 4; r++)
			if (blockState.rows[r] != 4'h0)
				pieceHeight = pieceHeight + 3'd1;
		timerDone = int'(fallTimer) == fallPeriod - 1;
		atBottom = {2'b00, pieceRow} + {3'b000, pieceHeight} >=
			6'(fieldRows) - {1'b0, stackHeight};
		stackSum = {1'b0, stackHeight} + {3'b000, pieceHeight};
	end

	always_ff @(posedge Clk)
	begin
		if (!rstN)
		begin
			fallTimer <= '0;
			pieceRow <= '0;
			stackHeight <= '0;
			landed <= 1'b0;
			field.hitBottom <= 1'b0;
		end
		else
		begin
			field.hitBottom <= 1'b0;
			if (field.resetBlocks)
			begin
				fallTimer <= '0;
				pieceRow <= '0;
				landed <= 1'b0;
				if (field.pause) // Title and end screen.
					stackHeight <= '0;
			end
			else if (!field.pause && !landed)
			begin
				fallTimer <= timerDone ? '0 : fallTimer + 1'b1;
				if (timerDone && atBottom)
				begin
					field.hitBottom <= 1'b1;
					landed <= 1'b1;
					stackHeight <= (stackSum > 6'(fieldRows)) ? 5'(fieldRows) : stackSum[4:0];
				end
				else if (timerDone)
					pieceRow <= pieceRow + 4'd1;
			end
		end
	end

	assign field.endGame = stackHeight >= 5'(stackLimit);

	stackBounded: assert property (@(posedge Clk) disable iff (!rstN)
		stackHeight <= 5'(fieldRows))
		else $error("Stack height %h above field", stackHeight);

endmodule

//--- logic/tetrisPkg.sv
package tetrisPkg;

	// Keyboard codes as levels from the keyboard block.
	localparam logic [7:0] keySpace = 8'h2C;
	localparam logic [7:0] keyPause = 8'd19;  // P
	localparam logic [7:0] keyResume = 8'd24; // U
	localparam logic [7:0] keyHold = 8'd43;   // Tab
	localparam logic [7:0] keyEscape = 8'h29;

	// Screen select for the video side.
	localparam logic [2:0] screenPlay = 3'd0;
	localparam logic [2:0] screenPaused = 3'd1;
	localparam logic [2:0] screenTitle = 3'd2;
	localparam logic [2:0] screenEnd = 3'd3;

	localparam int fieldRows = 16;
	localparam int fallPeriod = 4; // Clocks per fall step.
	localparam int stackLimit = 12;

	localparam logic [15:0] lfsrSeed = 16'hACE1;

	// Flat word for moving pieces around, rows for measuring them.
	typedef union packed
	{
		logic [15:0] flat;
		logic [3:0][3:0] rows;
	} pieceShape_t;

	// Top row in the high nibble.
	localparam logic [15:0] shapeTable [7] = '{
		16'h4444, // Upright I.
		16'h6600, // O
		16'h4E00, // T
		16'h6C00, // S
		16'hC600, // Z
		16'h8E00, // J
		16'h2E00  // L
	};

endpackage

//--- logic/tetrisTop.sv
`timescale 1ns/1ps

module tetrisTop
(
	input logic Clk,
	input logic rstN,
	input logic [7:0] keyCode,
	output logic [15:0] blockState,
	output logic [15:0] holdState,
	output logic [15:0] queueState,
	output logic [5:0] spriteIndex,
	output logic [5:0] holdIndex,
	output logic [5:0] queueIndex,
	output logic pause,
	output logic [2:0] screen,
	output logic [3:0] pieceRow,
	output logic [4:0] stackHeight
);

	fieldIf fieldBus();

	gameController controller
	(
		.Clk,
		.rstN,
		.keyCode,
		.field(fieldBus.ctrl),
		.blockState,
		.spriteIndex,
		.holdState,
		.holdIndex,
		.queueState,
		.queueIndex,
		.screen
	);

	playfieldTracker tracker
	(
		.Clk,
		.rstN,
		.field(fieldBus.field),
		.blockState,
		.pieceRow,
		.stackHeight
	);

	assign pause = fieldBus.pause;

endmodule

//--- sim/tetrisTb.sv
`timescale 1ns/1ps

module tetrisTb import tetrisPkg::*; ();

	typedef struct
	{
		logic [7:0] key;
		int holdCycles;
		logic [2:0] expScreen;
		logic expPause;
	} stepRow_t;

	logic Clk = 1'b0;
	logic rstN;
	logic [7:0] keyCode;
	logic [15:0] blockState, holdState, queueState;
	logic [5:0] spriteIndex, holdIndex, queueIndex;
	logic pause;
	logic [2:0] screen;
	logic [3:0] pieceRow;
	logic [4:0] stackHeight;

	stepRow_t steps [9];
	logic [15:0] modelLfsr = lfsrSeed;
	int curIdx, queueIdx, holdIdx, genIdx; // Model of the piece slots and the generator output.
	int modelStack = 0; // Stack height the model predicts.
	int valueErrors = 0;
	int timeouts = 0;

	tetrisTop UUT (.*);

	always #5 Clk = ~Clk;

	task automatic finishRun();
		$display("Errors: %0d value, %0d timeout", valueErrors, timeouts);
		if (valueErrors == 0 && timeouts == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	endtask

	task automatic checkValue(input string name, input logic [15:0] got, input logic [15:0] exp);
		assert (got === exp)
		else
		begin
			valueErrors++;
			$display("ERR %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic reportTimeout(input string what);
		timeouts++;
		$display("Timed out while waiting for %s", what);
	endtask

	// Fibonacci LFSR with taps 16, 14, 13 and 11.
	task automatic nextPick(output int idx);
		modelLfsr = {modelLfsr[14:0], ^(modelLfsr & 16'hB400)};
		idx = modelLfsr[2:0] % 7;
	endtask

	task automatic dropPiece();
		curIdx = queueIdx;
		queueIdx = genIdx;
		nextPick(genIdx);
	endtask

	function automatic int rowCount(input logic [15:0] shape);
		int n;
		n = 0;
		for (int r = 0; r < 4; r++)
			if (shape[4*r +: 4] != 4'h0)
				n++;
		return n;
	endfunction

	task automatic checkPieces();
		checkValue("blockState", blockState, shapeTable[curIdx]);
		checkValue("spriteIndex", 16'(spriteIndex), 16'(curIdx));
		checkValue("queueState", queueState, shapeTable[queueIdx]);
		checkValue("queueIndex", 16'(queueIndex), 16'(queueIdx));
		checkValue("holdState", holdState, (holdIdx < 0) ? 16'h0000 : shapeTable[holdIdx]);
		if (holdIdx >= 0)
			checkValue("holdIndex", 16'(holdIndex), 16'(holdIdx));
	endtask

	task automatic pressKey(input logic [7:0] key, input int cycles);
		@(posedge Clk);
		#1 keyCode = key;
		repeat (cycles) @(posedge Clk);
		#1 keyCode = 8'h00;
	endtask

	task automatic waitScreen(input logic [2:0] exp);
		int count;
		count = 0;
		@(negedge Clk);
		while (screen !== exp && count < 2000)
		begin
			@(negedge Clk);
			count++;
		end
		if (count >= 2000)
			reportTimeout("a screen change");
	endtask

	task automatic applyRow(input int i);
		pressKey(steps[i].key, steps[i].holdCycles);
		waitScreen(steps[i].expScreen);
		checkValue("pause", 16'(pause), 16'(steps[i].expPause));
		repeat ($urandom % 4) @(negedge Clk);
	endtask

	// The stack grows by the rows of the landed piece.
	task automatic waitLanding();
		int count;
		int expStack;
		expStack = modelStack + rowCount(shapeTable[curIdx]);
		if (expStack > fieldRows)
			expStack = fieldRows;
		count = 0;
		while (stackHeight === 5'(modelStack) && count < 2000)
		begin
			@(negedge Clk);
			count++;
		end
		if (count >= 2000)
			reportTimeout("a piece to land");
		else
			checkValue("stackHeight", 16'(stackHeight), 16'(expStack));
		modelStack = expStack;
	endtask

	// Pieces land without keys until the stack ends the game.
	task automatic landUntilEnd();
		for (int n = 0; n < 16 && modelStack < stackLimit; n++)
		begin
			waitLanding();
			if (modelStack < stackLimit)
			begin
				dropPiece();
				repeat (6) @(negedge Clk);
				checkPieces();
			end
		end
		waitScreen(screenEnd);
		checkValue("pause", 16'(pause), 16'h0001);
	endtask

	initial
	begin
		logic [3:0] frozenRow;
		int swapIdx;
		void'($urandom(32'hf9aebaab));
		steps = '{
			'{keySpace, 1, screenPlay, 1'b0},
			'{keyPause, 2, screenPaused, 1'b1},
			'{keyResume, 1, screenPlay, 1'b0},
			'{keyHold, 1, screenPlay, 1'b0},
			'{keyHold, 1, screenPlay, 1'b0},   // Second hold in one drop.
			'{keyHold, 1, screenPlay, 1'b0},
			'{keyEscape, 1, screenTitle, 1'b1},
			'{keySpace, 1, screenPlay, 1'b0},
			'{keyEscape, 1, screenTitle, 1'b1}
		};
		rstN = 1'b0;
		keyCode = 8'h00;
		holdIdx = -1;
		repeat (10) @(posedge Clk);
		#1 rstN = 1'b1;
		@(negedge Clk);
		checkValue("screen", 16'(screen), 16'(screenTitle));
		checkValue("pause", 16'(pause), 16'h0001);
		checkValue("holdState", holdState, 16'h0000);
		checkValue("stackHeight", 16'(stackHeight), 16'h0000);
		nextPick(queueIdx);
		nextPick(genIdx);
		repeat (4) @(negedge Clk);

		for (int i = 0; i < $size(steps); i++)
		begin
			applyRow(i);
			case (i)
				0:
				begin
					dropPiece();
					repeat (3) @(negedge Clk);
					checkPieces();
				end
				1:
				begin
					frozenRow = pieceRow;
					repeat (40) @(negedge Clk);
					checkValue("pieceRow", 16'(pieceRow), 16'(frozenRow));
				end
				3:
				begin
					holdIdx = curIdx;
					dropPiece();
					repeat (3) @(negedge Clk);
					checkPieces();
				end
				4:
				begin
					repeat (3) @(negedge Clk);
					checkPieces();
					waitLanding();
					dropPiece();
					repeat (6) @(negedge Clk);
					checkPieces();
				end
				5:
				begin
					swapIdx = curIdx;
					curIdx = holdIdx;
					holdIdx = swapIdx;
					repeat (3) @(negedge Clk);
					checkPieces();
					landUntilEnd();
				end
				6:
				begin
					repeat (2) @(negedge Clk);
					checkValue("stackHeight", 16'(stackHeight), 16'h0000);
					checkValue("holdState", holdState, 16'h0000);
					holdIdx = -1;
					modelStack = 0;
				end
				7:
				begin
					dropPiece();
					repeat (3) @(negedge Clk);
					checkPieces();
					waitLanding();
					dropPiece();
					repeat (6) @(negedge Clk);
					checkPieces();
				end
				8:
				begin
					repeat (2) @(negedge Clk); // Escape straight from play.
					checkValue("stackHeight", 16'(stackHeight), 16'h0000);
				end
				default:
				begin
				end
			endcase
		end
		finishRun();
	end

endmodule

//--- tetrisTop.f
logic/tetrisPkg.sv
logic/fieldIf.sv
logic/pieceGenerator.sv
logic/gameController.sv
logic/playfieldTracker.sv
logic/tetrisTop.sv
sim/tetrisTb.sv
